// ==== build.f ====
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/id_ex_reg.sv
hw/exec_unit.sv
hw/hazard_ctrl.sv
hw/mips_slice_top.sv
test/mips_slice_checker.sv
test/tb_mips_slice.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the simulation with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_mips_slice -f build.f -o sim_tb; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb +verilator+error+limit+100)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// ==== test/tb_mips_slice.sv ====
`timescale 1ns/1ps

`include "slice_settings.svh"

module tb_mips_slice;

    localparam int NUM_INSTR    = 400;
    localparam int BURST        = 60;   // Full-rate issue without back-pressure.
    localparam int ISSUE_LIMIT  = 4000;
    localparam int DRAIN_LIMIT  = 200;

    typedef struct packed {
        logic                we;
        pipe_pkg::reg_addr_t rd;
        pipe_pkg::data_t     data;
        logic                taken;
        pipe_pkg::pc_t       target;
        logic                pulsed;
    } ret_entry_t;

    logic                clk;
    logic                i_arst_n;
    logic                i_instr_valid;
    pipe_pkg::instr_t    i_instr;
    pipe_pkg::pc_t       i_pc;
    logic                o_instr_ready;
    logic                o_ret_valid;
    logic                o_ret_we;
    pipe_pkg::reg_addr_t o_ret_rd;
    pipe_pkg::data_t     o_ret_data;
    logic                i_ret_ready;
    logic                o_redirect_valid;
    pipe_pkg::pc_t       o_redirect_pc;

    logic [15:0]         lfsr_state;
    pipe_pkg::data_t     model_rf [`NUM_REGS];
    ret_entry_t          exp_q [$];
    pipe_pkg::pc_t       next_pc;
    logic                branch_pending; // Next accepted instruction is squashed.
    logic                accepted_now;
    int                  issued;
    int                  cycles;
    int                  taken_seen;
    int                  stall_seen;

    mips_slice_top i_mips_slice_top (
        .clk(clk), .i_arst_n(i_arst_n), .i_instr_valid(i_instr_valid), .i_instr(i_instr),
        .i_pc(i_pc), .o_instr_ready(o_instr_ready), .o_ret_valid(o_ret_valid),
        .o_ret_we(o_ret_we), .o_ret_rd(o_ret_rd), .o_ret_data(o_ret_data),
        .i_ret_ready(i_ret_ready), .o_redirect_valid(o_redirect_valid),
        .o_redirect_pc(o_redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Random source and failure reporting
    ////////////////////////////////////////////////////////////
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r          = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            abort_run($sformatf("mismatch %s: expected %h actual %h", name, expected, actual));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////////////////////////
    function automatic pipe_pkg::instr_t make_instr();
        int          sel;
        logic [31:0] r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        sel = take_bits(4) % 9;
        r   = take_bits(2);
        rs  = r[4:0];       // Registers 0 to 3 keep dependencies dense.
        r   = take_bits(2);
        rt  = r[4:0];
        r   = take_bits(2);
        rd  = r[4:0];
        r   = take_bits(16);
        imm = r[15:0];
        case (sel)
            0: return {isa_pkg::OP_RTYPE, rs, rt, rd, 5'd0, isa_pkg::FN_ADDU};
            1: return {isa_pkg::OP_RTYPE, rs, rt, rd, 5'd0, isa_pkg::FN_SUBU};
            2: return {isa_pkg::OP_RTYPE, rs, rt, rd, 5'd0, isa_pkg::FN_AND};
            3: return {isa_pkg::OP_RTYPE, rs, rt, rd, 5'd0, isa_pkg::FN_OR};
            4: return {isa_pkg::OP_RTYPE, rs, rt, rd, 5'd0, isa_pkg::FN_SLT};
            5: return {isa_pkg::OP_ADDIU, rs, rt, imm};
            6: return {isa_pkg::OP_ORI, rs, rt, imm};
            7: return {isa_pkg::OP_LUI, rs, rt, imm};
            default: return {isa_pkg::OP_BEQ, rs, rt, imm};
        endcase
    endfunction

    task automatic model_issue(input pipe_pkg::instr_t instr, input pipe_pkg::pc_t pc,
                               output logic taken);
        ret_entry_t      e;
        pipe_pkg::data_t a;
        pipe_pkg::data_t b;
        pipe_pkg::data_t sext;
        pipe_pkg::data_t zext;
        a    = model_rf[instr[25:21]];
        b    = model_rf[instr[20:16]];
        sext = {{16{instr[15]}}, instr[15:0]};
        zext = {16'h0000, instr[15:0]};
        e    = '0;
        e.we = 1'b1;
        e.rd = instr[20:16];
        case (instr[31:26])
            isa_pkg::OP_RTYPE: begin
                e.rd = instr[15:11];
                case (instr[5:0])
                    isa_pkg::FN_ADDU: e.data = a + b;
                    isa_pkg::FN_SUBU: e.data = a - b;
                    isa_pkg::FN_AND:  e.data = a & b;
                    isa_pkg::FN_OR:   e.data = a | b;
                    default:          e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                endcase
            end
            isa_pkg::OP_ADDIU: e.data = a + sext;
            isa_pkg::OP_ORI:   e.data = a | zext;
            isa_pkg::OP_LUI:   e.data = {instr[15:0], 16'h0000};
            default: begin // Only BEQ is left.
                e.we     = 1'b0;
                e.rd     = '0;
                e.taken  = (a == b);
                e.target = pc + 32'd4 + (sext << 2);
            end
        endcase
        if (e.we && e.rd != '0) model_rf[e.rd] = e.data;
        exp_q.push_back(e);
        taken = e.taken;
    endtask

    // Mid-cycle look at the ports; everything here happens at the next edge.
    task automatic sample_cycle();
        ret_entry_t e;
        int         idx;
        logic       taken;
        @(negedge clk);
        if (i_mips_slice_top.i_checker.fail_count != 0) begin
            abort_run("protocol assertion failed in the checker");
        end
        if (o_ret_valid && !i_ret_ready) stall_seen++;
        if (o_redirect_valid) begin
            idx = o_ret_valid ? 1 : 0; // Branch sits behind a full retire register.
            assert (exp_q.size() > idx) else abort_run("redirect with no branch in execute");
            e = exp_q[idx];
            check_value("redirect_taken", 32'd1, 32'(e.taken));
            check_value("redirect_pc", e.target, o_redirect_pc);
            e.pulsed    = 1'b1;
            exp_q[idx]  = e;
            taken_seen++;
        end
        if (o_ret_valid && i_ret_ready) begin
            assert (exp_q.size() > 0) else abort_run("retirement with nothing outstanding");
            e = exp_q.pop_front();
            check_value("retire_we", 32'(e.we), 32'(o_ret_we));
            check_value("retire_redirect", 32'(e.taken), 32'(e.pulsed));
            if (e.we) begin
                check_value("retire_rd", 32'(e.rd), 32'(o_ret_rd));
                check_value("retire_data", e.data, o_ret_data);
            end
        end
        accepted_now = i_instr_valid && o_instr_ready;
        if (o_instr_ready) begin
            taken = 1'b0;
            if (i_instr_valid && !branch_pending) model_issue(i_instr, i_pc, taken);
            if (i_instr_valid) issued++;
            branch_pending = taken;
        end
    endtask

    task automatic drive_cycle();
        @(posedge clk);
        #1;
        if (accepted_now || !i_instr_valid) begin
            if (issued < NUM_INSTR && (issued < BURST || take_bits(2) != 0)) begin
                i_instr       = make_instr();
                i_pc          = next_pc;
                i_instr_valid = 1'b1;
                next_pc       = next_pc + 32'd4;
            end else begin
                i_instr_valid = 1'b0;
            end
        end
        i_ret_ready = (issued < BURST) || (take_bits(2) != 0);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        lfsr_state     = 16'd5;
        i_arst_n       = 1'b0;
        i_instr_valid  = 1'b0;
        i_instr        = '0;
        i_pc           = '0;
        i_ret_ready    = 1'b1;
        next_pc        = 32'h0000_1000;
        branch_pending = 1'b0;
        accepted_now   = 1'b0;
        issued         = 0;
        taken_seen     = 0;
        stall_seen     = 0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_rf[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        i_arst_n = 1'b1;

        cycles = 0;
        while (issued < NUM_INSTR) begin
            sample_cycle();
            drive_cycle();
            cycles++;
            if (cycles > ISSUE_LIMIT) abort_run("timeout waiting for instructions to issue");
        end
        cycles = 0;
        while (exp_q.size() != 0) begin
            sample_cycle();
            drive_cycle();
            cycles++;
            if (cycles > DRAIN_LIMIT) abort_run("timeout waiting for retirements");
        end

        assert (taken_seen > 0 && stall_seen > 0) else begin
            abort_run("stimulus reached no taken branch or no stall");
        end
        if (i_mips_slice_top.i_checker.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run("protocol assertion failed in the checker");
        end
    end

endmodule

// ==== test/mips_slice_checker.sv ====
`timescale 1ns/1ps

module mips_slice_checker (
    input logic                clk,
    input logic                i_arst_n,
    input logic                i_instr_valid,
    input logic                i_instr_ready,
    input logic                i_ret_valid,
    input logic                i_ret_we,
    input pipe_pkg::reg_addr_t i_ret_rd,
    input pipe_pkg::data_t     i_ret_data,
    input logic                i_ret_ready,
    input logic                i_redirect_valid
);

    int unsigned fail_count = 0; // Failed assertions so far.

    ////////////////////////////////////////////////////////////
    // Reset state
    ////////////////////////////////////////////////////////////
    a_reset_idle: assert property (@(posedge clk)
        (!i_arst_n || $rose(i_arst_n)) |-> (!i_ret_valid && !i_redirect_valid && i_instr_ready))
        else begin
            $error("outputs not idle during reset");
            fail_count++;
        end

    ////////////////////////////////////////////////////////////
    // Retire port back-pressure and latency
    ////////////////////////////////////////////////////////////
    a_stall_blocks_issue: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_ret_valid && !i_ret_ready) |-> !i_instr_ready)
        else begin
            $error("issue port ready while retire port is stalled");
            fail_count++;
        end

    a_stall_holds_retire: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_ret_valid && !i_ret_ready) |=>
        (i_ret_valid && $stable(i_ret_we) && $stable(i_ret_rd) && $stable(i_ret_data)))
        else begin
            $error("retire outputs changed while stalled");
            fail_count++;
        end

    // One cycle from acceptance to retire valid when the pipe moves.
    a_retire_latency: assert property (@(posedge clk) disable iff (!i_arst_n)
        ($past(i_instr_valid && i_instr_ready && !i_redirect_valid) && i_instr_ready)
        |=> i_ret_valid)
        else begin
            $error("retire valid late after acceptance");
            fail_count++;
        end

    a_redirect_one_cycle: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_redirect_valid |=> !i_redirect_valid)
        else begin
            $error("redirect held longer than one cycle");
            fail_count++;
        end

endmodule

bind mips_slice_top mips_slice_checker i_checker (
    .clk(clk), .i_arst_n(i_arst_n), .i_instr_valid(i_instr_valid),
    .i_instr_ready(o_instr_ready), .i_ret_valid(o_ret_valid), .i_ret_we(o_ret_we),
    .i_ret_rd(o_ret_rd), .i_ret_data(o_ret_data), .i_ret_ready(i_ret_ready),
    .i_redirect_valid(o_redirect_valid)
);

// ==== hw/mips_slice_top.sv ====
`timescale 1ns/1ps

module mips_slice_top (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic                i_instr_valid,
    input  pipe_pkg::instr_t    i_instr,
    input  pipe_pkg::pc_t       i_pc,
    output logic                o_instr_ready,
    output logic                o_ret_valid,
    output logic                o_ret_we,
    output pipe_pkg::reg_addr_t o_ret_rd,
    output pipe_pkg::data_t     o_ret_data,
    input  logic                i_ret_ready,
    output logic                o_redirect_valid,
    output pipe_pkg::pc_t       o_redirect_pc
);

    ////////////////////////////////////////////////////////////
    // Decode stage signals
    ////////////////////////////////////////////////////////////
    pipe_pkg::reg_addr_t id_rs, id_rt, id_rd;
    pipe_pkg::data_t     id_imm, id_rdata_a, id_rdata_b;
    isa_pkg::alu_op_t    id_alu_op;
    logic                id_alu_src_imm, id_reg_write, id_is_beq;

    // Execute stage signals.
    pipe_pkg::pc_t       ex_pc;
    pipe_pkg::reg_addr_t ex_rs, ex_rt, ex_rd;
    pipe_pkg::data_t     ex_imm, ex_rdata_a, ex_rdata_b;
    isa_pkg::alu_op_t    ex_alu_op;
    logic                ex_alu_src_imm, ex_reg_write, ex_is_beq, ex_valid;
    logic                ex_taken;

    logic                hz_enable, hz_flush;
    pipe_pkg::fwd_sel_t  hz_fwd_a, hz_fwd_b;
    logic                rf_we;

    assign rf_we            = o_ret_valid && i_ret_ready && o_ret_we; // Write on retirement.
    assign o_instr_ready    = hz_enable;
    assign o_redirect_valid = ex_taken && hz_enable;

    instr_decoder u_instr_decoder (
        .i_instr(i_instr), .o_rs(id_rs), .o_rt(id_rt), .o_rd(id_rd), .o_imm(id_imm),
        .o_alu_op(id_alu_op), .o_alu_src_imm(id_alu_src_imm),
        .o_reg_write(id_reg_write), .o_is_beq(id_is_beq)
    );

    reg_file u_reg_file (
        .clk(clk), .i_arst_n(i_arst_n), .i_raddr_a(id_rs), .i_raddr_b(id_rt),
        .i_we(rf_we), .i_waddr(o_ret_rd), .i_wdata(o_ret_data),
        .o_rdata_a(id_rdata_a), .o_rdata_b(id_rdata_b)
    );

    id_ex_reg u_id_ex_reg (
        .clk(clk), .i_arst_n(i_arst_n), .i_enable(hz_enable), .i_flush(hz_flush),
        .i_pc(i_pc), .i_rs(id_rs), .i_rt(id_rt), .i_rd(id_rd),
        .i_rdata_a(id_rdata_a), .i_rdata_b(id_rdata_b), .i_imm(id_imm),
        .i_alu_op(id_alu_op), .i_alu_src_imm(id_alu_src_imm),
        .i_reg_write(id_reg_write), .i_is_beq(id_is_beq), .i_valid(i_instr_valid),
        .o_pc(ex_pc), .o_rs(ex_rs), .o_rt(ex_rt), .o_rd(ex_rd),
        .o_rdata_a(ex_rdata_a), .o_rdata_b(ex_rdata_b), .o_imm(ex_imm),
        .o_alu_op(ex_alu_op), .o_alu_src_imm(ex_alu_src_imm),
        .o_reg_write(ex_reg_write), .o_is_beq(ex_is_beq), .o_valid(ex_valid)
    );

    exec_unit u_exec_unit (
        .clk(clk), .i_arst_n(i_arst_n), .i_enable(hz_enable),
        .i_fwd_a(hz_fwd_a), .i_fwd_b(hz_fwd_b), .i_pc(ex_pc), .i_rd(ex_rd),
        .i_rdata_a(ex_rdata_a), .i_rdata_b(ex_rdata_b), .i_imm(ex_imm),
        .i_alu_op(ex_alu_op), .i_alu_src_imm(ex_alu_src_imm),
        .i_reg_write(ex_reg_write), .i_is_beq(ex_is_beq), .i_valid(ex_valid),
        .o_taken(ex_taken), .o_redirect_pc(o_redirect_pc),
        .o_ret_valid(o_ret_valid), .o_ret_we(o_ret_we),
        .o_ret_rd(o_ret_rd), .o_ret_data(o_ret_data)
    );

    hazard_ctrl u_hazard_ctrl (
        .i_ex_rs(ex_rs), .i_ex_rt(ex_rt), .i_ex_valid(ex_valid),
        .i_ret_valid(o_ret_valid), .i_ret_we(o_ret_we), .i_ret_rd(o_ret_rd),
        .i_ret_ready(i_ret_ready), .i_taken(ex_taken),
        .o_enable(hz_enable), .o_flush(hz_flush), .o_fwd_a(hz_fwd_a), .o_fwd_b(hz_fwd_b)
    );

endmodule

// ==== hw/hazard_ctrl.sv ====
`timescale 1ns/1ps

module hazard_ctrl (
    input  pipe_pkg::reg_addr_t i_ex_rs,
    input  pipe_pkg::reg_addr_t i_ex_rt,
    input  logic                i_ex_valid,
    input  logic                i_ret_valid,
    input  logic                i_ret_we,
    input  pipe_pkg::reg_addr_t i_ret_rd,
    input  logic                i_ret_ready,
    input  logic                i_taken,
    output logic                o_enable,
    output logic                o_flush,
    output pipe_pkg::fwd_sel_t  o_fwd_a,
    output pipe_pkg::fwd_sel_t  o_fwd_b
);

    logic ret_writes;

    // Retire register holds a live result for a real register.
    assign ret_writes = i_ex_valid && i_ret_valid && i_ret_we && (i_ret_rd != '0);

    assign o_fwd_a = (ret_writes && (i_ret_rd == i_ex_rs)) ? pipe_pkg::FWD_RET
                                                           : pipe_pkg::FWD_RF;
    assign o_fwd_b = (ret_writes && (i_ret_rd == i_ex_rt)) ? pipe_pkg::FWD_RET
                                                           : pipe_pkg::FWD_RF;

    // Whole pipe holds while a result waits at the retire port.
    assign o_enable = !(i_ret_valid && !i_ret_ready);
    assign o_flush  = i_taken && o_enable; // Squash the younger instruction.

endmodule

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic                i_enable,
    input  pipe_pkg::fwd_sel_t  i_fwd_a,
    input  pipe_pkg::fwd_sel_t  i_fwd_b,
    input  pipe_pkg::pc_t       i_pc,
    input  pipe_pkg::reg_addr_t i_rd,
    input  pipe_pkg::data_t     i_rdata_a,
    input  pipe_pkg::data_t     i_rdata_b,
    input  pipe_pkg::data_t     i_imm,
    input  isa_pkg::alu_op_t    i_alu_op,
    input  logic                i_alu_src_imm,
    input  logic                i_reg_write,
    input  logic                i_is_beq,
    input  logic                i_valid,
    output logic                o_taken,
    output pipe_pkg::pc_t       o_redirect_pc,
    output logic                o_ret_valid,
    output logic                o_ret_we,
    output pipe_pkg::reg_addr_t o_ret_rd,
    output pipe_pkg::data_t     o_ret_data
);

    pipe_pkg::data_t op_a;
    pipe_pkg::data_t op_b;
    pipe_pkg::data_t alu_b;
    pipe_pkg::data_t alu_res;

    ////////////////////////////////////////////////////////////
    // Operands and ALU
    ////////////////////////////////////////////////////////////
    assign op_a  = (i_fwd_a == pipe_pkg::FWD_RET) ? o_ret_data : i_rdata_a;
    assign op_b  = (i_fwd_b == pipe_pkg::FWD_RET) ? o_ret_data : i_rdata_b;
    assign alu_b = i_alu_src_imm ? i_imm : op_b;

    always_comb begin
        case (i_alu_op)
            isa_pkg::ALU_SUB: alu_res = op_a - alu_b;
            isa_pkg::ALU_AND: alu_res = op_a & alu_b;
            isa_pkg::ALU_OR:  alu_res = op_a | alu_b;
            isa_pkg::ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(alu_b)};
            isa_pkg::ALU_LUI: alu_res = {alu_b[15:0], 16'h0000};
            default:          alu_res = op_a + alu_b;
        endcase
    end

    // Branch outcome and target.
    assign o_taken       = i_valid && i_is_beq && (op_a == op_b);
    assign o_redirect_pc = i_pc + 32'd4 + (i_imm << 2);

    ////////////////////////////////////////////////////////////
    // Retire register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ret_valid <= 1'b0;
            o_ret_we    <= 1'b0;
            o_ret_rd    <= '0;
        end else if (i_enable) begin
            o_ret_valid <= i_valid; // Empty slot when nothing new arrives.
            o_ret_we    <= i_valid && i_reg_write;
            o_ret_rd    <= i_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (i_enable) o_ret_data <= alu_res;
    end

endmodule

// ==== hw/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic                i_enable,
    input  logic                i_flush,
    input  pipe_pkg::pc_t       i_pc,
    input  pipe_pkg::reg_addr_t i_rs,
    input  pipe_pkg::reg_addr_t i_rt,
    input  pipe_pkg::reg_addr_t i_rd,
    input  pipe_pkg::data_t     i_rdata_a,
    input  pipe_pkg::data_t     i_rdata_b,
    input  pipe_pkg::data_t     i_imm,
    input  isa_pkg::alu_op_t    i_alu_op,
    input  logic                i_alu_src_imm,
    input  logic                i_reg_write,
    input  logic                i_is_beq,
    input  logic                i_valid,
    output pipe_pkg::pc_t       o_pc,
    output pipe_pkg::reg_addr_t o_rs,
    output pipe_pkg::reg_addr_t o_rt,
    output pipe_pkg::reg_addr_t o_rd,
    output pipe_pkg::data_t     o_rdata_a,
    output pipe_pkg::data_t     o_rdata_b,
    output pipe_pkg::data_t     o_imm,
    output isa_pkg::alu_op_t    o_alu_op,
    output logic                o_alu_src_imm,
    output logic                o_reg_write,
    output logic                o_is_beq,
    output logic                o_valid
);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc          <= '0;
            o_rs          <= '0;
            o_rt          <= '0;
            o_rd          <= '0;
            o_rdata_a     <= '0;
            o_rdata_b     <= '0;
            o_imm         <= '0;
            o_alu_op      <= isa_pkg::ALU_ADD;
            o_alu_src_imm <= 1'b0;
            o_reg_write   <= 1'b0;
            o_is_beq      <= 1'b0;
            o_valid       <= 1'b0;
        end else if (i_flush) begin // Bubble behind a taken branch.
            o_pc          <= '0;
            o_rs          <= '0;
            o_rt          <= '0;
            o_rd          <= '0;
            o_rdata_a     <= '0;
            o_rdata_b     <= '0;
            o_imm         <= '0;
            o_alu_op      <= isa_pkg::ALU_ADD;
            o_alu_src_imm <= 1'b0;
            o_reg_write   <= 1'b0;
            o_is_beq      <= 1'b0;
            o_valid       <= 1'b0;
        end else if (i_enable) begin
            o_pc          <= i_pc;
            o_rs          <= i_rs;
            o_rt          <= i_rt;
            o_rd          <= i_rd;
            o_rdata_a     <= i_rdata_a;
            o_rdata_b     <= i_rdata_b;
            o_imm         <= i_imm;
            o_alu_op      <= i_alu_op;
            o_alu_src_imm <= i_alu_src_imm;
            o_reg_write   <= i_reg_write;
            o_is_beq      <= i_is_beq;
            o_valid       <= i_valid;
        end
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

`include "slice_settings.svh"

module reg_file (
    input  logic                clk,
    input  logic                i_arst_n,
    input  pipe_pkg::reg_addr_t i_raddr_a,
    input  pipe_pkg::reg_addr_t i_raddr_b,
    input  logic                i_we,
    input  pipe_pkg::reg_addr_t i_waddr,
    input  pipe_pkg::data_t     i_wdata,
    output pipe_pkg::data_t     o_rdata_a,
    output pipe_pkg::data_t     o_rdata_b
);

    pipe_pkg::data_t regs [`NUM_REGS];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Register 0 is hardwired; a write in the same cycle passes straight through.
    assign o_rdata_a = (i_raddr_a == '0)                  ? '0      :
                       (i_we && (i_waddr == i_raddr_a))   ? i_wdata : regs[i_raddr_a];
    assign o_rdata_b = (i_raddr_b == '0)                  ? '0      :
                       (i_we && (i_waddr == i_raddr_b))   ? i_wdata : regs[i_raddr_b];

endmodule

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  pipe_pkg::instr_t    i_instr,
    output pipe_pkg::reg_addr_t o_rs,
    output pipe_pkg::reg_addr_t o_rt,
    output pipe_pkg::reg_addr_t o_rd,
    output pipe_pkg::data_t     o_imm,
    output isa_pkg::alu_op_t    o_alu_op,
    output logic                o_alu_src_imm,
    output logic                o_reg_write,
    output logic                o_is_beq
);

    isa_pkg::opcode_t opcode;
    isa_pkg::funct_t  funct;
    pipe_pkg::data_t  imm_sext;
    pipe_pkg::data_t  imm_zext;

    assign opcode   = isa_pkg::opcode_t'(i_instr[31:26]);
    assign funct    = isa_pkg::funct_t'(i_instr[5:0]);
    assign imm_sext = {{16{i_instr[15]}}, i_instr[15:0]};
    assign imm_zext = {16'h0000, i_instr[15:0]};

    assign o_rs = i_instr[25:21];
    assign o_rt = i_instr[20:16];

    always_comb begin
        o_rd          = '0;
        o_imm         = '0;
        o_alu_op      = isa_pkg::ALU_ADD;
        o_alu_src_imm = 1'b0;
        o_reg_write   = 1'b0;
        o_is_beq      = 1'b0;
        case (opcode)
            isa_pkg::OP_RTYPE: begin
                o_rd        = i_instr[15:11];
                o_reg_write = 1'b1;
                case (funct)
                    isa_pkg::FN_ADDU: o_alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: o_alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  o_alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:   o_alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_SLT:  o_alu_op = isa_pkg::ALU_SLT;
                    default:          o_reg_write = 1'b0; // Unknown funct is a no-op.
                endcase
            end
            isa_pkg::OP_ADDIU: begin
                o_rd          = i_instr[20:16];
                o_imm         = imm_sext;
                o_alu_src_imm = 1'b1;
                o_reg_write   = 1'b1;
            end
            isa_pkg::OP_ORI: begin
                o_rd          = i_instr[20:16];
                o_imm         = imm_zext;
                o_alu_op      = isa_pkg::ALU_OR;
                o_alu_src_imm = 1'b1;
                o_reg_write   = 1'b1;
            end
            isa_pkg::OP_LUI: begin
                o_rd          = i_instr[20:16];
                o_imm         = imm_zext;
                o_alu_op      = isa_pkg::ALU_LUI;
                o_alu_src_imm = 1'b1;
                o_reg_write   = 1'b1;
            end
            isa_pkg::OP_BEQ: begin
                o_imm    = imm_sext; // Word offset for the target.
                o_alu_op = isa_pkg::ALU_SUB;
                o_is_beq = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== hw/pipe_pkg.sv ====
`include "slice_settings.svh"

package pipe_pkg;

    ////////////////////////////////////////////////////////////
    // Pipeline word types
    ////////////////////////////////////////////////////////////
    typedef logic [`DATA_W-1:0]     data_t;     // Operand or result.
    typedef logic [`PC_W-1:0]       pc_t;       // Byte address.
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t; // Register index.
    typedef logic [31:0]            instr_t;    // Instruction word.

    // Operand source in execute.
    typedef enum logic {
        FWD_RF  = 1'b0, // Value read in decode.
        FWD_RET = 1'b1  // Value held in the retire register.
    } fwd_sel_t;

endpackage

// ==== hw/isa_pkg.sv ====
package isa_pkg;

    // Primary opcodes, instr[31:26].
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDIU = 6'h09,
        OP_ORI   = 6'h0D,
        OP_LUI   = 6'h0F
    } opcode_t;

    // R-type function codes, instr[5:0].
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2A
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5  // Immediate into the upper half.
    } alu_op_t;

endpackage

// ==== hw/slice_settings.svh ====
`ifndef SLICE_SETTINGS_SVH
`define SLICE_SETTINGS_SVH

// Datapath word width.
`define DATA_W 32

// Program counter width, byte addressed.
`define PC_W 32

// Register index width and register count.
`define REG_ADDR_W 5
`define NUM_REGS 32

`endif
